// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;

    // register 0 always reads zero
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU,
        LOAD,
        STORE,
        MULT,
        MULTU,
        DIV,
        DIVU,
        BRANCH,
        JUMP,
        NOP
    } op_t;

    typedef struct packed {
        op_t  op;
        logic regwrite;
        logic branch;
        logic jump;
    } ctl_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     raw_instr;
        ctl_t      ctl;
        reg_addr_t ra1;
        reg_addr_t ra2;
        reg_addr_t rdst;
        word_t     imm;
        logic      is_slot;
    } decode_data_t;

    // source numbers replaced by resolved operand values
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     raw_instr;
        ctl_t      ctl;
        reg_addr_t rdst;
        word_t     imm;
        logic      is_slot;
        word_t     rd1;
        word_t     rd2;
    } issue_data_t;

    function automatic logic is_multi_op(op_t op);
        return op inside {MULT, MULTU, DIV, DIVU};
    endfunction

    // r0 never counts as a dependency
    function automatic logic reads_reg(decode_data_t d, reg_addr_t r);
        return (r != '0) && ((d.ra1 == r) || (d.ra2 == r));
    endfunction

    function automatic issue_data_t to_issue(decode_data_t d, word_t a, word_t b);
        issue_data_t r;
        r.valid     = d.valid;
        r.pc        = d.pc;
        r.raw_instr = d.raw_instr;
        r.ctl       = d.ctl;
        r.rdst      = d.rdst;
        r.imm       = d.imm;
        r.is_slot   = d.is_slot;
        r.rd1       = a;
        r.rd2       = b;
        return r;
    endfunction

endpackage

`default_nettype wire

// File: regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t ra1 [1:0],
    input  cpu_pkg::reg_addr_t ra2 [1:0],
    output cpu_pkg::word_t     rd1 [1:0],
    output cpu_pkg::word_t     rd2 [1:0],
    input  logic [1:0]         wen,
    input  cpu_pkg::reg_addr_t waddr [1:0],
    input  cpu_pkg::word_t     wdata [1:0]
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // port 1 goes first so port 0 lands last on a clash
            for (int p = 1; p >= 0; p--) begin
                if (wen[p] && (waddr[p] != '0)) begin
                    regs[waddr[p]] <= wdata[p];
                end
            end
        end
    end

    // no write-through, new values show up a cycle later
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            rd1[s] = (ra1[s] == '0) ? '0 : regs[ra1[s]];
            rd2[s] = (ra2[s] == '0) ? '0 : regs[ra2[s]];
        end
    end

endmodule

`default_nettype wire

// File: forward_unit.sv
`timescale 1ns/10ps
`default_nettype none

module forward_unit (
    input  cpu_pkg::reg_addr_t ra1 [1:0],
    input  cpu_pkg::reg_addr_t ra2 [1:0],
    input  cpu_pkg::word_t     rf_rd1 [1:0],
    input  cpu_pkg::word_t     rf_rd2 [1:0],
    input  logic [1:0]         ex_valid,
    input  logic [1:0]         ex_ready,
    input  cpu_pkg::reg_addr_t ex_rdst [1:0],
    input  cpu_pkg::word_t     ex_data [1:0],
    output cpu_pkg::word_t     opnd1 [1:0],
    output cpu_pkg::word_t     opnd2 [1:0],
    output logic [1:0]         opnd_ready
);
    import cpu_pkg::*;

    typedef struct packed {
        logic  ready;
        word_t data;
    } fwd_t;

    fwd_t f1 [1:0];
    fwd_t f2 [1:0];

    // producer 1 first, producer 0 overrides as the younger one
    function automatic fwd_t resolve(
        reg_addr_t  addr,
        word_t      rf_val,
        logic [1:0] pv,
        logic [1:0] pr,
        reg_addr_t  pdst [1:0],
        word_t      pdata [1:0]
    );
        fwd_t r;
        r.ready = 1'b1;
        r.data  = rf_val;
        if (addr != '0) begin
            for (int p = 1; p >= 0; p--) begin
                if (pv[p] && (pdst[p] == addr)) begin
                    r.ready = pr[p];
                    r.data  = pdata[p];
                end
            end
        end
        return r;
    endfunction

    for (genvar s = 0; s < 2; s++) begin : g_slot
        assign f1[s] = resolve(ra1[s], rf_rd1[s], ex_valid, ex_ready, ex_rdst, ex_data);
        assign f2[s] = resolve(ra2[s], rf_rd2[s], ex_valid, ex_ready, ex_rdst, ex_data);

        assign opnd1[s] = f1[s].data;
        assign opnd2[s] = f2[s].data;

        // a pending load on either source holds the slot
        assign opnd_ready[s] = f1[s].ready & f2[s].ready;
    end

endmodule

`default_nettype wire

// File: issue_queue.sv
`timescale 1ns/10ps
`default_nettype none

module issue_queue #(
    parameter int ISSUE_QUEUE_DEPTH = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  flush,
    input  cpu_pkg::decode_data_t dec_data [1:0],
    output cpu_pkg::reg_addr_t    cand_ra1 [1:0],
    output cpu_pkg::reg_addr_t    cand_ra2 [1:0],
    input  cpu_pkg::word_t        opnd1 [1:0],
    input  cpu_pkg::word_t        opnd2 [1:0],
    input  logic [1:0]            opnd_ready,
    output cpu_pkg::issue_data_t  iss_data [1:0],
    output logic                  dec_hold
);
    import cpu_pkg::*;

    localparam int PTR_W = $clog2(ISSUE_QUEUE_DEPTH);

    // extra top bit tells a full queue from an empty one
    typedef logic [PTR_W:0]   ptr_t;
    typedef logic [PTR_W-1:0] idx_t;

    decode_data_t mem [ISSUE_QUEUE_DEPTH];

    ptr_t head;
    ptr_t tail;
    ptr_t count;
    idx_t head_idx;
    idx_t head_nxt;
    idx_t tail_idx;
    idx_t tail_nxt;

    logic q_empty;
    logic q_one;
    logic dec_v1;
    logic dec_v0;

    decode_data_t cand1;
    decode_data_t cand0;

    logic hazard;
    logic en1;
    logic en0;

    logic [1:0] q_pop;
    logic [1:0] dec_taken;
    logic [1:0] n_push;

    decode_data_t push_a;
    decode_data_t push_b;

    assign count    = tail - head;
    assign q_empty  = (count == '0);
    assign q_one    = (count == ptr_t'(1));
    assign head_idx = head[PTR_W-1:0];
    assign head_nxt = head_idx + idx_t'(1);
    assign tail_idx = tail[PTR_W-1:0];
    assign tail_nxt = tail_idx + idx_t'(1);

    // fewer than two free entries
    assign dec_hold = (count > ptr_t'(ISSUE_QUEUE_DEPTH - 2));

    // a held pair is neither issued nor queued, decode shows it again
    assign dec_v1 = dec_data[1].valid & ~dec_hold;
    assign dec_v0 = dec_data[0].valid & ~dec_hold;

    // oldest two instructions in program order
    always_comb begin
        cand1       = dec_data[1];
        cand0       = dec_data[0];
        cand1.valid = dec_v1;
        cand0.valid = dec_v0;
        if (q_one) begin
            cand1       = mem[head_idx];
            cand0       = dec_data[1];
            cand0.valid = dec_v1;
        end else if (!q_empty) begin
            cand1 = mem[head_idx];
            cand0 = mem[head_nxt];
        end
    end

    assign cand_ra1[1] = cand1.ra1;
    assign cand_ra2[1] = cand1.ra2;
    assign cand_ra1[0] = cand0.ra1;
    assign cand_ra2[0] = cand0.ra2;

    // reasons the younger one cannot go with the older one
    assign hazard = (cand1.ctl.regwrite && reads_reg(cand0, cand1.rdst))
                 || (is_multi_op(cand1.ctl.op) && is_multi_op(cand0.ctl.op))
                 || cand0.ctl.branch
                 || cand0.ctl.jump;

    assign en1 = cand1.valid & opnd_ready[1];

    // delay slot skips the hazard check, not the in-order or operand checks
    assign en0 = cand0.valid & opnd_ready[0] & en1 & (~hazard | cand0.is_slot);

    // split issued count between queue entries and decode slots
    always_comb begin
        if (q_empty) begin
            q_pop     = 2'd0;
            dec_taken = {1'b0, en1} + {1'b0, en0};
        end else if (q_one) begin
            q_pop     = {1'b0, en1};
            dec_taken = {1'b0, en0};
        end else begin
            q_pop     = {1'b0, en1} + {1'b0, en0};
            dec_taken = 2'd0;
        end
        n_push = {1'b0, dec_v1} + {1'b0, dec_v0} - dec_taken;
        // oldest decode instruction left behind goes in first
        push_a = (dec_taken == 2'd0) ? dec_data[1] : dec_data[0];
        push_b = dec_data[0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else if (flush) begin
            head <= tail;
        end else if (!stall) begin
            head <= head + ptr_t'(q_pop);
            tail <= tail + ptr_t'(n_push);
        end
    end

    always_ff @(posedge clk) begin
        if (!flush && !stall) begin
            if (n_push != 2'd0) begin
                mem[tail_idx] <= push_a;
            end
            if (n_push == 2'd2) begin
                mem[tail_nxt] <= push_b;
            end
        end
    end

    assign iss_data[1] = en1 ? to_issue(cand1, opnd1[1], opnd2[1]) : '0;
    assign iss_data[0] = en0 ? to_issue(cand0, opnd1[0], opnd2[0]) : '0;

endmodule

`default_nettype wire

// File: issue_stage.sv
`timescale 1ns/10ps
`default_nettype none

module issue_stage #(
    parameter int ISSUE_QUEUE_DEPTH = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_pkg::decode_data_t dec_data [1:0],
    input  logic                  stall,
    input  logic                  flush,
    input  logic [1:0]            ex_valid,
    input  cpu_pkg::reg_addr_t    ex_rdst [1:0],
    input  logic [1:0]            ex_ready,
    input  cpu_pkg::word_t        ex_data [1:0],
    input  logic [1:0]            wb_en,
    input  cpu_pkg::reg_addr_t    wb_addr [1:0],
    input  cpu_pkg::word_t        wb_data [1:0],
    output cpu_pkg::issue_data_t  iss_data [1:0],
    output logic                  dec_hold
);
    import cpu_pkg::*;

    reg_addr_t  cand_ra1 [1:0];
    reg_addr_t  cand_ra2 [1:0];
    word_t      rf_rd1 [1:0];
    word_t      rf_rd2 [1:0];
    word_t      opnd1 [1:0];
    word_t      opnd2 [1:0];
    logic [1:0] opnd_ready;

    issue_queue #(
        .ISSUE_QUEUE_DEPTH(ISSUE_QUEUE_DEPTH)
    ) u_queue (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .flush      (flush),
        .dec_data   (dec_data),
        .cand_ra1   (cand_ra1),
        .cand_ra2   (cand_ra2),
        .opnd1      (opnd1),
        .opnd2      (opnd2),
        .opnd_ready (opnd_ready),
        .iss_data   (iss_data),
        .dec_hold   (dec_hold)
    );

    // operands for the current candidates
    forward_unit u_fwd (
        .ra1        (cand_ra1),
        .ra2        (cand_ra2),
        .rf_rd1     (rf_rd1),
        .rf_rd2     (rf_rd2),
        .ex_valid   (ex_valid),
        .ex_ready   (ex_ready),
        .ex_rdst    (ex_rdst),
        .ex_data    (ex_data),
        .opnd1      (opnd1),
        .opnd2      (opnd2),
        .opnd_ready (opnd_ready)
    );

    regfile u_rf (
        .clk   (clk),
        .rst   (rst),
        .ra1   (cand_ra1),
        .ra2   (cand_ra2),
        .rd1   (rf_rd1),
        .rd2   (rf_rd2),
        .wen   (wb_en),
        .waddr (wb_addr),
        .wdata (wb_data)
    );

endmodule

`default_nettype wire

// File: issue_stage_sva.sv
`timescale 1ns/10ps
`default_nettype none

module issue_stage_sva #(
    parameter int PTR_W = 5
) (
    input logic           clk,
    input logic           rst,
    input logic           stall,
    input logic           flush,
    input logic [PTR_W:0] head,
    input logic [PTR_W:0] tail,
    input logic [1:0]     iss_v
);
    // read by the testbench after each row
    int fail_count = 0;

    // younger slot never leaves without the older one
    in_order: assert property (@(posedge clk) disable iff (rst) iss_v[0] |-> iss_v[1])
        else begin
            $error("slot 0 issued while slot 1 is empty");
            fail_count++;
        end

    flush_empties: assert property (@(posedge clk) disable iff (rst) flush |=> head == tail)
        else begin
            $error("queue not empty on the cycle after a flush");
            fail_count++;
        end

    // flush is allowed to move head under stall
    stall_holds: assert property (@(posedge clk) disable iff (rst)
        stall && !flush |=> $stable(head) && $stable(tail))
        else begin
            $error("queue pointers moved under stall");
            fail_count++;
        end

endmodule

bind issue_queue issue_stage_sva #(
    .PTR_W(PTR_W)
) u_sva (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .flush (flush),
    .head  (head),
    .tail  (tail),
    .iss_v ({iss_data[1].valid, iss_data[0].valid})
);

`default_nettype wire

// File: tb_issue_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_issue_stage;
    import cpu_pkg::*;

    localparam word_t EX0 = 32'h5a5a_0f00;
    localparam word_t EX1 = 32'h3c3c_00f1;
    // operand codes above 31 pick a producer instead of a register
    localparam logic [5:0] F0 = 6'd32;
    localparam logic [5:0] F1 = 6'd33;
    localparam int MAX_ROWS = 24;
    localparam decode_data_t NONE = '0;

    typedef struct packed {
        logic [4:0]   rep;
        decode_data_t d1;
        decode_data_t d0;
        logic [1:0]   exv;
        logic [1:0]   exr;
        reg_addr_t    exd1;
        reg_addr_t    exd0;
        logic         stall;
        logic         flush;
        logic [7:0]   pc1;
        logic [7:0]   pc0;
        logic [23:0]  ops;
        logic         hold;
    } row_t;

    logic         clk = 1'b0;
    logic         rst;
    logic         stall;
    logic         flush;
    decode_data_t dec_data [1:0];
    logic [1:0]   ex_valid;
    reg_addr_t    ex_rdst [1:0];
    logic [1:0]   ex_ready;
    word_t        ex_data [1:0];
    logic [1:0]   wb_en;
    reg_addr_t    wb_addr [1:0];
    word_t        wb_data [1:0];
    issue_data_t  iss_data [1:0];
    logic         dec_hold;

    word_t       shadow [32] = '{default: '0};
    row_t        rows [MAX_ROWS];
    int          n_rows = 0;
    int          row_cycles = 0;
    int          total_cycles = 0;
    int unsigned seed;

    issue_stage uut (.*);

    always #2 clk = ~clk;

    task automatic stop_run(string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    function automatic decode_data_t make_instr(logic [7:0] pc, op_t op, reg_addr_t rdst,
                                                reg_addr_t ra1, reg_addr_t ra2, logic slot);
        decode_data_t d;
        d              = '0;
        d.valid        = 1'b1;
        d.pc           = {24'h0, pc};
        d.ctl.op       = op;
        d.ctl.regwrite = (rdst != '0);
        d.ctl.branch   = (op == BRANCH);
        d.ctl.jump     = (op == JUMP);
        d.ra1          = ra1;
        d.ra2          = ra2;
        d.rdst         = rdst;
        d.is_slot      = slot;
        return d;
    endfunction

    task automatic add_row(int rep, decode_data_t d1, decode_data_t d0,
                           logic [1:0] exv, logic [1:0] exr, reg_addr_t exd1, reg_addr_t exd0,
                           logic st, logic fl, logic [7:0] pc1, logic [7:0] pc0,
                           logic [23:0] ops, logic hold);
        rows[n_rows] = '{rep, d1, d0, exv, exr, exd1, exd0, st, fl, pc1, pc0, ops, hold};
        n_rows++;
        row_cycles += rep;
    endtask

    function automatic word_t operand_value(logic [5:0] code);
        if (code == F0) begin
            return EX0;
        end
        if (code == F1) begin
            return EX1;
        end
        return shadow[code[4:0]];
    endfunction

    task automatic apply_row(row_t r);
        dec_data[1] = r.d1;
        dec_data[0] = r.d0;
        ex_valid    = r.exv;
        ex_ready    = r.exr;
        ex_rdst[1]  = r.exd1;
        ex_rdst[0]  = r.exd0;
        stall       = r.stall;
        flush       = r.flush;
        wb_en       = 2'b00;
    endtask

    // pc 0 in a row means the slot must be empty
    task automatic check_slot(int k, int s, logic [7:0] pc, logic [11:0] ops);
        issue_data_t got;
        word_t       exp_a;
        word_t       exp_b;
        got   = iss_data[s];
        exp_a = operand_value(ops[11:6]);
        exp_b = operand_value(ops[5:0]);
        assert (got.valid == (pc != 8'h00))
            else stop_run($sformatf("ERROR at %0t ns: row %0d slot %0d valid is %0b",
                                    $time, k, s, got.valid));
        if (pc != 8'h00) begin
            assert (got.pc == {24'h0, pc} && got.rd1 == exp_a && got.rd2 == exp_b)
                else stop_run($sformatf(
                    "ERROR at %0t ns: row %0d slot %0d got %h %h %h, expected %h %h %h",
                    $time, k, s, got.pc, got.rd1, got.rd2, pc, exp_a, exp_b));
        end
    endtask

    task automatic check_row(int k, row_t r);
        check_slot(k, 1, r.pc1, r.ops[23:12]);
        check_slot(k, 0, r.pc0, r.ops[11:0]);
        assert (dec_hold == r.hold)
            else stop_run($sformatf("ERROR at %0t ns: row %0d dec_hold is %0b, expected %0b",
                                    $time, k, dec_hold, r.hold));
        assert (uut.u_queue.u_sva.fail_count == 0)
            else stop_run("a queue assertion failed, see the message above");
    endtask

    initial begin
        rst         = 1'b1;
        stall       = 1'b0;
        flush       = 1'b0;
        dec_data[0] = '0;
        dec_data[1] = '0;
        ex_valid    = 2'b00;
        ex_ready    = 2'b00;
        ex_rdst[0]  = '0;
        ex_rdst[1]  = '0;
        ex_data[0]  = EX0;
        ex_data[1]  = EX1;
        wb_en       = 2'b00;
        wb_addr[0]  = '0;
        wb_addr[1]  = '0;
        wb_data[0]  = '0;
        wb_data[1]  = '0;
        seed        = 32'hfe34;
        void'($urandom(seed));

        // independent pair with a pending producer on r0, then a RAW hazard
        add_row(1, make_instr(8'h10, ALU, 9, 1, 2, 0), make_instr(8'h14, ALU, 10, 3, 0, 0),
                2'b01, 2'b00, 0, 0, 0, 0, 8'h10, 8'h14, {6'd1, 6'd2, 6'd3, 6'd0}, 0);
        add_row(1, make_instr(8'h18, ALU, 11, 4, 5, 0), make_instr(8'h1c, ALU, 12, 11, 6, 0),
                2'b00, 2'b00, 0, 0, 0, 0, 8'h18, 8'h00, {6'd4, 6'd5, 6'd0, 6'd0}, 0);
        add_row(1, make_instr(8'h20, MULT, 0, 7, 8, 0), make_instr(8'h24, DIV, 0, 1, 2, 0),
                2'b00, 2'b00, 0, 0, 0, 0, 8'h1c, 8'h20, {6'd11, 6'd6, 6'd7, 6'd8}, 0);
        // two multi ops back to back
        add_row(1, make_instr(8'h28, MULTU, 0, 3, 4, 0), make_instr(8'h2c, ALU, 13, 5, 6, 0),
                2'b00, 2'b00, 0, 0, 0, 0, 8'h24, 8'h00, {6'd1, 6'd2, 6'd0, 6'd0}, 0);
        add_row(1, make_instr(8'h30, ALU, 14, 1, 3, 0), make_instr(8'h34, BRANCH, 31, 2, 4, 0),
                2'b00, 2'b00, 0, 0, 0, 0, 8'h28, 8'h2c, {6'd3, 6'd4, 6'd5, 6'd6}, 0);
        add_row(1, NONE, NONE,
                2'b00, 2'b00, 0, 0, 0, 0, 8'h30, 8'h00, {6'd1, 6'd3, 6'd0, 6'd0}, 0);
        // delay slot reads the link register of the branch
        add_row(1, make_instr(8'h38, ALU, 16, 31, 5, 1), make_instr(8'h3c, ALU, 17, 6, 7, 0),
                2'b00, 2'b00, 0, 0, 0, 0, 8'h34, 8'h38, {6'd2, 6'd4, 6'd31, 6'd5}, 0);
        // forwarding, not-ready producer, then ready
        add_row(1, make_instr(8'h40, ALU, 18, 1, 2, 0), make_instr(8'h44, ALU, 19, 8, 20, 0),
                2'b11, 2'b11, 6, 6, 0, 0, 8'h3c, 8'h40, {F0, 6'd7, 6'd1, 6'd2}, 0);
        add_row(1, make_instr(8'h48, ALU, 21, 3, 0, 0), NONE,
                2'b11, 2'b01, 20, 3, 0, 0, 8'h00, 8'h00, 24'h0, 0);
        add_row(1, NONE, NONE,
                2'b11, 2'b11, 20, 3, 0, 0, 8'h44, 8'h48, {6'd8, F1, F0, 6'd0}, 0);
        // stall with one queued entry, then flush over stall
        add_row(1, make_instr(8'h50, ALU, 22, 1, 2, 0), make_instr(8'h54, ALU, 23, 22, 3, 0),
                2'b00, 2'b00, 0, 0, 0, 0, 8'h50, 8'h00, {6'd1, 6'd2, 6'd0, 6'd0}, 0);
        add_row(2, make_instr(8'h58, ALU, 24, 4, 5, 0), make_instr(8'h5c, ALU, 25, 6, 7, 0),
                2'b00, 2'b00, 0, 0, 1, 0, 8'h54, 8'h58, {6'd22, 6'd3, 6'd4, 6'd5}, 0);
        add_row(1, make_instr(8'h58, ALU, 24, 4, 5, 0), make_instr(8'h5c, ALU, 25, 6, 7, 0),
                2'b00, 2'b00, 0, 0, 0, 0, 8'h54, 8'h58, {6'd22, 6'd3, 6'd4, 6'd5}, 0);
        add_row(1, NONE, NONE,
                2'b01, 2'b00, 0, 6, 1, 1, 8'h00, 8'h00, 24'h0, 0);
        add_row(1, make_instr(8'h60, ALU, 26, 1, 2, 0), make_instr(8'h64, ALU, 27, 3, 4, 0),
                2'b00, 2'b00, 0, 0, 0, 0, 8'h60, 8'h64, {6'd1, 6'd2, 6'd3, 6'd4}, 0);
        // blocked head fills the queue two entries a cycle
        add_row(16, make_instr(8'h70, ALU, 28, 9, 1, 0), make_instr(8'h74, ALU, 29, 2, 3, 0),
                2'b01, 2'b00, 0, 9, 0, 0, 8'h00, 8'h00, 24'h0, 0);
        add_row(1, make_instr(8'h70, ALU, 28, 9, 1, 0), make_instr(8'h74, ALU, 29, 2, 3, 0),
                2'b01, 2'b00, 0, 9, 0, 0, 8'h00, 8'h00, 24'h0, 1);
        add_row(1, NONE, NONE,
                2'b01, 2'b01, 0, 9, 0, 0, 8'h70, 8'h74, {F0, 6'd1, 6'd2, 6'd3}, 1);
        add_row(1, NONE, NONE,
                2'b01, 2'b01, 0, 9, 0, 0, 8'h70, 8'h74, {F0, 6'd1, 6'd2, 6'd3}, 0);
        total_cycles = row_cycles + 20;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // warm-up writes r1..r8
        for (int i = 1; i <= 8; i += 2) begin
            @(negedge clk);
            wb_en      = 2'b11;
            wb_addr[0] = reg_addr_t'(i);
            wb_addr[1] = reg_addr_t'(i + 1);
            wb_data[0] = $urandom;
            wb_data[1] = $urandom;
            shadow[i]     = wb_data[0];
            shadow[i + 1] = wb_data[1];
        end
        // port 0 must win a clash on r8
        @(negedge clk);
        wb_addr[0] = 5'd8;
        wb_addr[1] = 5'd8;
        wb_data[0] = $urandom;
        wb_data[1] = $urandom;
        shadow[8]  = wb_data[0];
        // writes to r0 are dropped
        @(negedge clk);
        wb_addr[0] = 5'd0;
        wb_addr[1] = 5'd0;
        wb_data[0] = $urandom;
        wb_data[1] = $urandom;

        for (int k = 0; k < n_rows; k++) begin
            for (int j = 0; j < int'(rows[k].rep); j++) begin
                @(negedge clk);
                apply_row(rows[k]);
                #1;
                check_row(k, rows[k]);
            end
        end

        @(negedge clk);
        if (uut.u_queue.u_sva.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_run("a queue assertion failed on the last cycle");
        end
    end

    initial begin
        wait (total_cycles > 0);
        #(total_cycles * 4);
        stop_run("timeout: the issue stage test did not finish in time");
    end

endmodule

`default_nettype wire

// File: src.f
cpu_pkg.sv
regfile.sv
forward_unit.sv
issue_queue.sv
issue_stage.sv
issue_stage_sva.sv
tb_issue_stage.sv
